//--- Bender.yml
package:
  name: segre_core

sources:
  - segre_pkg.sv
  - segre_register_file.sv
  - segre_if_stage.sv
  - segre_id_stage.sv
  - segre_ex_stage.sv
  - segre_mem_arbiter.sv
  - segre_core.sv
  - target: test
    files:
      - tb_segre_core.sv

//--- segre_core.sv
`timescale 1ns/1ps
`default_nettype none

module segre_core #(
    parameter segre_pkg::addr_t BOOT_ADDR = 32'h0000_0000
) (
    input  logic              clk_i,
    input  logic              reset_i,

    // Main memory
    input  logic              mm_data_rdy_i,
    input  segre_pkg::word_t  mm_rd_data_i,
    output segre_pkg::word_t  mm_wr_data_o,
    output segre_pkg::addr_t  mm_addr_o,
    output segre_pkg::addr_t  mm_wr_addr_o,
    output logic              mm_rd_o,
    output logic              mm_wr_o
);

    import segre_pkg::*;

    mem_req_t  fetch_req;
    mem_req_t  data_req;
    logic      fetch_rdy;
    logic      data_rdy;
    word_t     rdata;
    fetch_id_t fetch_id;
    id_ex_t    id_ex;
    rf_write_t rf_write;
    redirect_t redirect;
    reg_addr_t raddr_a;
    reg_addr_t raddr_b;
    word_t     rf_data_a;
    word_t     rf_data_b;

    segre_if_stage #(
        .BOOT_ADDR (BOOT_ADDR)
    ) if_stage (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .redirect_i (redirect),
        .rdy_i      (fetch_rdy),
        .rdata_i    (rdata),
        .req_o      (fetch_req),
        .fetch_o    (fetch_id)
    );

    segre_id_stage id_stage (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .fetch_i      (fetch_id),
        .rf_data_a_i  (rf_data_a),
        .rf_data_b_i  (rf_data_b),
        .rf_raddr_a_o (raddr_a),
        .rf_raddr_b_o (raddr_b),
        .id_ex_o      (id_ex)
    );

    segre_register_file register_file (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .raddr_a_i (raddr_a),
        .raddr_b_i (raddr_b),
        .wr_i      (rf_write),
        .data_a_o  (rf_data_a),
        .data_b_o  (rf_data_b)
    );

    segre_ex_stage ex_stage (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .id_ex_i    (id_ex),
        .data_rdy_i (data_rdy),
        .rdata_i    (rdata),
        .data_req_o (data_req),
        .rf_write_o (rf_write),
        .redirect_o (redirect)
    );

    // Single port shared by fetch and load/store
    segre_mem_arbiter mem_arbiter (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .fetch_req_i   (fetch_req),
        .data_req_i    (data_req),
        .mm_data_rdy_i (mm_data_rdy_i),
        .mm_rd_data_i  (mm_rd_data_i),
        .fetch_rdy_o   (fetch_rdy),
        .data_rdy_o    (data_rdy),
        .rdata_o       (rdata),
        .mm_rd_o       (mm_rd_o),
        .mm_wr_o       (mm_wr_o),
        .mm_addr_o     (mm_addr_o),
        .mm_wr_addr_o  (mm_wr_addr_o),
        .mm_wr_data_o  (mm_wr_data_o)
    );

endmodule : segre_core

`default_nettype wire

//--- segre_ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module segre_ex_stage (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  segre_pkg::id_ex_t     id_ex_i,
    input  logic                  data_rdy_i,
    input  segre_pkg::word_t      rdata_i,
    output segre_pkg::mem_req_t   data_req_o,
    output segre_pkg::rf_write_t  rf_write_o,
    output segre_pkg::redirect_t  redirect_o
);

    import segre_pkg::*;

    typedef enum logic [1:0] {
        idle,
        mem_wait,
        finish
    } ex_state_e;

    ex_state_e state_q;
    word_t     alu_res;
    logic      taken;
    word_t     res_q;
    word_t     st_data_q;
    addr_t     new_pc_q;
    reg_addr_t rd_q;
    logic      we_q;
    logic      taken_q;
    logic      mem_rd_q;
    logic      mem_wr_q;

    always_comb begin
        unique case (id_ex_i.alu_op)
            alu_add:  alu_res = id_ex_i.op_a + id_ex_i.op_b;
            alu_sub:  alu_res = id_ex_i.op_a - id_ex_i.op_b;
            alu_and:  alu_res = id_ex_i.op_a & id_ex_i.op_b;
            alu_or:   alu_res = id_ex_i.op_a | id_ex_i.op_b;
            alu_xor:  alu_res = id_ex_i.op_a ^ id_ex_i.op_b;
            alu_slt:  alu_res = {31'b0, $signed(id_ex_i.op_a) < $signed(id_ex_i.op_b)};
            alu_sltu: alu_res = {31'b0, id_ex_i.op_a < id_ex_i.op_b};
            alu_sll:  alu_res = id_ex_i.op_a << id_ex_i.op_b[4:0];
            alu_srl:  alu_res = id_ex_i.op_a >> id_ex_i.op_b[4:0];
            alu_sra:  alu_res = $signed(id_ex_i.op_a) >>> id_ex_i.op_b[4:0];
            default:  alu_res = id_ex_i.op_b;
        endcase
    end

    // Branches compare rs1 against rs2 carried in op_b
    always_comb begin
        case (id_ex_i.br_op)
            br_beq:  taken = (id_ex_i.op_a == id_ex_i.op_b);
            br_bne:  taken = (id_ex_i.op_a != id_ex_i.op_b);
            br_blt:  taken = ($signed(id_ex_i.op_a) < $signed(id_ex_i.op_b));
            br_bge:  taken = ($signed(id_ex_i.op_a) >= $signed(id_ex_i.op_b));
            br_jal:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= idle;
        end else begin
            case (state_q)
                idle: begin
                    if (id_ex_i.valid) begin
                        res_q     <= alu_res;
                        st_data_q <= id_ex_i.st_data;
                        new_pc_q  <= taken ? id_ex_i.br_target : id_ex_i.pc + 32'd4;
                        taken_q   <= taken;
                        rd_q      <= id_ex_i.rd;
                        we_q      <= id_ex_i.rf_we;
                        mem_rd_q  <= id_ex_i.mem_rd;
                        mem_wr_q  <= id_ex_i.mem_wr;
                        state_q   <= (id_ex_i.mem_rd || id_ex_i.mem_wr) ? mem_wait : finish;
                    end
                end
                mem_wait: begin
                    if (data_rdy_i) begin
                        // Load data replaces the address
                        if (mem_rd_q) begin
                            res_q <= rdata_i;
                        end
                        state_q <= finish;
                    end
                end
                default: state_q <= idle;
            endcase
        end
    end

    // res_q holds the address while waiting on memory
    assign data_req_o.rd    = (state_q == mem_wait) && mem_rd_q;
    assign data_req_o.wr    = (state_q == mem_wait) && mem_wr_q;
    assign data_req_o.addr  = res_q;
    assign data_req_o.wdata = st_data_q;

    assign rf_write_o.we    = (state_q == finish) && we_q;
    assign rf_write_o.waddr = rd_q;
    assign rf_write_o.wdata = res_q;

    assign redirect_o.done   = (state_q == finish);
    assign redirect_o.taken  = taken_q;
    assign redirect_o.new_pc = new_pc_q;

    // A new record only arrives once the previous instruction has retired
    a_valid_when_idle: assert property (@(posedge clk_i) disable iff (reset_i)
        id_ex_i.valid |-> state_q == idle);

endmodule : segre_ex_stage

`default_nettype wire

//--- segre_id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module segre_id_stage (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  segre_pkg::fetch_id_t  fetch_i,
    input  segre_pkg::word_t      rf_data_a_i,
    input  segre_pkg::word_t      rf_data_b_i,
    output segre_pkg::reg_addr_t  rf_raddr_a_o,
    output segre_pkg::reg_addr_t  rf_raddr_b_o,
    output segre_pkg::id_ex_t     id_ex_o
);

    import segre_pkg::*;

    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;

    word_t      instr;
    logic [6:0] opcode;
    logic [2:0] funct3;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    alu_op_e    alu_fn;
    br_op_e     br_cond;
    id_ex_t     id_ex_d;

    assign instr  = fetch_i.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    assign rf_raddr_a_o = instr[19:15];
    assign rf_raddr_b_o = instr[24:20];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // funct7 bit 30 picks sub (register form only) and sra
    always_comb begin
        unique case (funct3)
            3'b000:  alu_fn = (opcode == opc_op && instr[30]) ? alu_sub : alu_add;
            3'b001:  alu_fn = alu_sll;
            3'b010:  alu_fn = alu_slt;
            3'b011:  alu_fn = alu_sltu;
            3'b100:  alu_fn = alu_xor;
            3'b101:  alu_fn = instr[30] ? alu_sra : alu_srl;
            3'b110:  alu_fn = alu_or;
            default: alu_fn = alu_and;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  br_cond = br_beq;
            3'b001:  br_cond = br_bne;
            3'b100:  br_cond = br_blt;
            3'b101:  br_cond = br_bge;
            default: br_cond = br_none;
        endcase
    end

    always_comb begin
        id_ex_d           = '0;
        id_ex_d.valid     = fetch_i.valid;
        id_ex_d.pc        = fetch_i.pc;
        id_ex_d.op_a      = rf_data_a_i;
        id_ex_d.op_b      = rf_data_b_i;
        id_ex_d.st_data   = rf_data_b_i;
        id_ex_d.br_target = fetch_i.pc + imm_b;
        id_ex_d.alu_op    = alu_add;
        id_ex_d.br_op     = br_none;
        id_ex_d.rd        = instr[11:7];
        case (opcode)
            opc_op: begin
                id_ex_d.alu_op = alu_fn;
                id_ex_d.rf_we  = 1'b1;
            end
            opc_op_imm: begin
                id_ex_d.op_b   = imm_i;
                id_ex_d.alu_op = alu_fn;
                id_ex_d.rf_we  = 1'b1;
            end
            opc_lui: begin
                id_ex_d.op_b   = imm_u;
                id_ex_d.alu_op = alu_pass_b;
                id_ex_d.rf_we  = 1'b1;
            end
            opc_load: begin
                id_ex_d.op_b   = imm_i;
                id_ex_d.mem_rd = 1'b1;
                id_ex_d.rf_we  = 1'b1;
            end
            opc_store: begin
                id_ex_d.op_b   = imm_s;
                id_ex_d.mem_wr = 1'b1;
            end
            opc_branch: begin
                id_ex_d.br_op = br_cond;
            end
            opc_jal: begin
                // Link value pc+4 comes out of the ALU
                id_ex_d.op_a      = fetch_i.pc;
                id_ex_d.op_b      = 32'd4;
                id_ex_d.br_op     = br_jal;
                id_ex_d.br_target = fetch_i.pc + imm_j;
                id_ex_d.rf_we     = 1'b1;
            end
            default: begin
                // Unknown opcode retires as a nop
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        id_ex_o <= id_ex_d;
        if (reset_i) begin
            id_ex_o.valid <= 1'b0;
        end
    end

endmodule : segre_id_stage

`default_nettype wire

//--- segre_if_stage.sv
`timescale 1ns/1ps
`default_nettype none

module segre_if_stage #(
    parameter segre_pkg::addr_t BOOT_ADDR = 32'h0000_0000
) (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  segre_pkg::redirect_t  redirect_i,
    input  logic                  rdy_i,
    input  segre_pkg::word_t      rdata_i,
    output segre_pkg::mem_req_t   req_o,
    output segre_pkg::fetch_id_t  fetch_o
);

    import segre_pkg::*;

    typedef enum logic {
        fetch_wait,
        exec_wait
    } if_state_e;

    if_state_e state_q;
    addr_t     pc_q;

    // Read request held for the whole fetch_wait state
    assign req_o.rd    = (state_q == fetch_wait);
    assign req_o.wr    = 1'b0;
    assign req_o.addr  = pc_q;
    assign req_o.wdata = '0;

    always_ff @(posedge clk_i) begin
        fetch_o.valid <= 1'b0;
        if (reset_i) begin
            state_q <= fetch_wait;
            pc_q    <= BOOT_ADDR;
        end else begin
            case (state_q)
                fetch_wait: begin
                    if (rdy_i) begin
                        fetch_o.valid <= 1'b1;
                        fetch_o.pc    <= pc_q;
                        fetch_o.instr <= rdata_i;
                        state_q       <= exec_wait;
                    end
                end
                exec_wait: begin
                    // Next fetch once the instruction retires
                    if (redirect_i.done) begin
                        pc_q    <= redirect_i.taken ? redirect_i.new_pc : pc_q + 32'd4;
                        state_q <= fetch_wait;
                    end
                end
                default: state_q <= fetch_wait;
            endcase
        end
    end

    // Memory must not answer a fetch that is not outstanding
    a_no_rdy_in_exec: assert property (@(posedge clk_i) disable iff (reset_i)
        state_q == exec_wait |-> !rdy_i);

endmodule : segre_if_stage

`default_nettype wire

//--- segre_mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module segre_mem_arbiter (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  segre_pkg::mem_req_t  fetch_req_i,
    input  segre_pkg::mem_req_t  data_req_i,
    input  logic                 mm_data_rdy_i,
    input  segre_pkg::word_t     mm_rd_data_i,
    output logic                 fetch_rdy_o,
    output logic                 data_rdy_o,
    output segre_pkg::word_t     rdata_o,
    output logic                 mm_rd_o,
    output logic                 mm_wr_o,
    output segre_pkg::addr_t     mm_addr_o,
    output segre_pkg::addr_t     mm_wr_addr_o,
    output segre_pkg::word_t     mm_wr_data_o
);

    import segre_pkg::*;

    typedef enum logic {
        idle,
        busy
    } arb_state_e;

    arb_state_e state_q;
    logic       owner_data_q;
    mem_req_t   cur_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q      <= idle;
            owner_data_q <= 1'b0;
        end else begin
            case (state_q)
                idle: begin
                    // Data side wins a tie
                    if (data_req_i.rd || data_req_i.wr) begin
                        cur_q        <= data_req_i;
                        owner_data_q <= 1'b1;
                        state_q      <= busy;
                    end else if (fetch_req_i.rd || fetch_req_i.wr) begin
                        cur_q        <= fetch_req_i;
                        owner_data_q <= 1'b0;
                        state_q      <= busy;
                    end
                end
                busy: begin
                    if (mm_data_rdy_i) begin
                        state_q <= idle;
                    end
                end
                default: state_q <= idle;
            endcase
        end
    end

    assign mm_rd_o      = (state_q == busy) && cur_q.rd;
    assign mm_wr_o      = (state_q == busy) && cur_q.wr;
    assign mm_addr_o    = cur_q.addr;
    assign mm_wr_addr_o = cur_q.addr;
    assign mm_wr_data_o = cur_q.wdata;

    // Ready pulse goes back to whoever owns the transaction
    assign fetch_rdy_o = (state_q == busy) && !owner_data_q && mm_data_rdy_i;
    assign data_rdy_o  = (state_q == busy) && owner_data_q && mm_data_rdy_i;
    assign rdata_o     = mm_rd_data_i;

    a_rd_wr_exclusive: assert property (@(posedge clk_i) disable iff (reset_i)
        !(mm_rd_o && mm_wr_o));

endmodule : segre_mem_arbiter

`default_nettype wire

//--- segre_pkg.sv
`default_nettype none

package segre_pkg;

    // Widths with a meaning
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_pass_b
    } alu_op_e;

    typedef enum logic [2:0] {
        br_none,
        br_beq,
        br_bne,
        br_blt,
        br_bge,
        br_jal
    } br_op_e;

    typedef struct packed {
        logic  valid;
        addr_t pc;
        word_t instr;
    } fetch_id_t;

    // Everything execute needs for one instruction
    typedef struct packed {
        logic      valid;
        addr_t     pc;
        word_t     op_a;
        word_t     op_b;
        word_t     st_data;
        addr_t     br_target;
        alu_op_e   alu_op;
        br_op_e    br_op;
        logic      rf_we;
        reg_addr_t rd;
        logic      mem_rd;
        logic      mem_wr;
    } id_ex_t;

    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
    } rf_write_t;

    typedef struct packed {
        logic  done;
        logic  taken;
        addr_t new_pc;
    } redirect_t;

    typedef struct packed {
        logic  rd;
        logic  wr;
        addr_t addr;
        word_t wdata;
    } mem_req_t;

endpackage : segre_pkg

`default_nettype wire

//--- segre_register_file.sv
`timescale 1ns/1ps
`default_nettype none

module segre_register_file (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  segre_pkg::reg_addr_t  raddr_a_i,
    input  segre_pkg::reg_addr_t  raddr_b_i,
    input  segre_pkg::rf_write_t  wr_i,
    output segre_pkg::word_t      data_a_o,
    output segre_pkg::word_t      data_b_o
);

    import segre_pkg::*;

    word_t regs_q [32];

    // x0 is cleared by reset and never written
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_i.we && wr_i.waddr != 5'd0) begin
            regs_q[wr_i.waddr] <= wr_i.wdata;
        end
    end

    assign data_a_o = regs_q[raddr_a_i];
    assign data_b_o = regs_q[raddr_b_i];

endmodule : segre_register_file

`default_nettype wire

//--- segre_testdata.txt
# tag address data, then an optional note
# M = memory word (program or data), S = expected store in order
M 00000000 00001537 lui  x10,0x1
M 00000004 00500093 addi x1,x0,5
M 00000008 FFD00113 addi x2,x0,-3
M 0000000C 002081B3 add  x3,x1,x2
M 00000010 40110233 sub  x4,x2,x1
M 00000014 403252B3 sra  x5,x4,x3
M 00000018 00325333 srl  x6,x4,x3
M 0000001C 001123B3 slt  x7,x2,x1
M 00000020 00113433 sltu x8,x2,x1
M 00000024 001244B3 xor  x9,x4,x1
M 00000028 F0352023 sw x3,-256(x10)
M 0000002C F0552223 sw x5,-252(x10)
M 00000030 F0652423 sw x6,-248(x10)
M 00000034 F0752623 sw x7,-244(x10)
M 00000038 F0852823 sw x8,-240(x10)
M 0000003C F0952A23 sw x9,-236(x10)
M 00000040 ABCDE5B7 lui  x11,0xABCDE
M 00000044 1235E593 ori  x11,x11,0x123
M 00000048 00309633 sll  x12,x1,x3
M 0000004C 0FF5F693 andi x13,x11,0xff
M 00000050 00D66733 or   x14,x12,x13
M 00000054 F0B52C23 sw x11,-232(x10)
M 00000058 F0E52E23 sw x14,-228(x10)
M 0000005C 4045D793 srai x15,x11,4
M 00000060 F2F52023 sw x15,-224(x10)
M 00000064 80052803 lw   x16,-2048(x10)
M 00000068 00180833 add  x16,x16,x1
M 0000006C F3052223 sw x16,-220(x10)
M 00000070 04D00013 addi x0,x0,77
M 00000074 F2052423 sw x0,-216(x10)
M 00000078 00108463 beq x1,x1,+8 taken
M 0000007C F2252623 sw x2,-212(x10) skipped
M 00000080 00109463 bne x1,x1,+8 not taken
M 00000084 F2152623 sw x1,-212(x10)
M 00000088 00114463 blt x2,x1,+8 taken
M 0000008C F2252823 sw x2,-208(x10) skipped
M 00000090 00115463 bge x2,x1,+8 not taken
M 00000094 F2352823 sw x3,-208(x10)
M 00000098 00208463 beq x1,x2,+8 not taken
M 0000009C 00209463 bne x1,x2,+8 taken
M 000000A0 F2252A23 sw x2,-204(x10) skipped
M 000000A4 0020C463 blt x1,x2,+8 not taken
M 000000A8 0020D463 bge x1,x2,+8 taken
M 000000AC F2252A23 sw x2,-204(x10) skipped
M 000000B0 00C008EF jal x17,+12
M 000000B4 F2252A23 sw x2,-204(x10) skipped
M 000000B8 F2252A23 sw x2,-204(x10) skipped
M 000000BC F3152A23 sw x17,-204(x10)
M 000000C0 FE152E23 sw x1,-4(x10) last store
M 00000800 00000100 data word for lw
S 00000F00 00000002 add
S 00000F04 FFFFFFFE sra
S 00000F08 3FFFFFFE srl
S 00000F0C 00000001 slt
S 00000F10 00000000 sltu
S 00000F14 FFFFFFFD xor
S 00000F18 ABCDE123 lui and ori
S 00000F1C 00000037 sll, andi, or
S 00000F20 FABCDE12 srai
S 00000F24 00000105 lw plus add
S 00000F28 00000000 x0 stays zero
S 00000F2C 00000005 after bne not taken
S 00000F30 00000002 after bge not taken
S 00000F34 000000B4 jal link
S 00000FFC 00000005 end of program

//--- sources.f
segre_pkg.sv
segre_register_file.sv
segre_if_stage.sv
segre_id_stage.sv
segre_ex_stage.sv
segre_mem_arbiter.sv
segre_core.sv
tb_segre_core.sv

//--- tb_segre_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_segre_core;

    import segre_pkg::*;

    localparam addr_t BOOT_ADDR       = 32'h0000_0000;
    localparam addr_t LAST_STORE_ADDR = 32'h0000_0FFC;
    localparam int    MEM_WORDS       = 1024;

    logic   clk_i;
    logic   reset_i;
    logic   mm_data_rdy_i;
    word_t  mm_rd_data_i;
    word_t  mm_wr_data_o;
    addr_t  mm_addr_o;
    addr_t  mm_wr_addr_o;
    logic   mm_rd_o;
    logic   mm_wr_o;

    word_t  mem [MEM_WORDS];
    addr_t  exp_addr [$];
    word_t  exp_data [$];
    int     image_words;
    int     store_idx;
    int     errors;
    int     wait_cnt;
    int     reset_edges;
    integer seed;
    logic   busy;
    logic   first_read_seen;
    logic   done;
    logic   load_ok;

    segre_core #(
        .BOOT_ADDR (BOOT_ADDR)
    ) segre_core_inst (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .mm_data_rdy_i (mm_data_rdy_i),
        .mm_rd_data_i  (mm_rd_data_i),
        .mm_wr_data_o  (mm_wr_data_o),
        .mm_addr_o     (mm_addr_o),
        .mm_wr_addr_o  (mm_wr_addr_o),
        .mm_rd_o       (mm_rd_o),
        .mm_wr_o       (mm_wr_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            errors++;
            $display("error: %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic load_testdata();
        int         fd;
        int         count;
        logic [7:0] tag;
        word_t      addr;
        word_t      data;
        string      line;
        // Unused words never decode to a real opcode
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'hBAD0_0000 | (i << 2);
        end
        fd = $fopen("segre_testdata.txt", "r");
        if (fd == 0) begin
            errors++;
            load_ok = 1'b0;
            $display("could not open segre_testdata.txt for reading");
        end else begin
            while (!$feof(fd)) begin
                line  = "";
                count = $fgets(line, fd);
                count = $sscanf(line, "%c %h %h", tag, addr, data);
                if (count == 3 && tag == "M") begin
                    mem[addr[11:2]] = data;
                    image_words++;
                end else if (count == 3 && tag == "S") begin
                    exp_addr.push_back(addr);
                    exp_data.push_back(data);
                end
            end
            $fclose(fd);
            load_ok = 1'b1;
        end
    endtask

    task automatic record_store();
        if (store_idx < exp_addr.size()) begin
            check_value($sformatf("store %0d address", store_idx), exp_addr[store_idx],
                        mm_wr_addr_o);
            check_value($sformatf("store %0d data", store_idx), exp_data[store_idx],
                        mm_wr_data_o);
        end else begin
            errors++;
            $display("store to %h arrived after the expected sequence had ended", mm_wr_addr_o);
        end
        store_idx++;
        mem[mm_wr_addr_o[11:2]] = mm_wr_data_o;
        if (mm_wr_addr_o == LAST_STORE_ADDR) begin
            done <= 1'b1;
        end
    endtask

    // Main memory model with one request at a time and 1 to 4 cycles of latency
    always @(posedge clk_i) begin
        mm_data_rdy_i <= 1'b0;
        if (reset_i) begin
            busy = 1'b0;
            // Core state is still unknown on the first edge
            if (reset_edges > 0) begin
                check_value("rd during reset", 32'd0, {31'b0, mm_rd_o});
                check_value("wr during reset", 32'd0, {31'b0, mm_wr_o});
            end
            reset_edges++;
        end else begin
            check_value("rd and wr overlap", 32'd0, {31'b0, mm_rd_o & mm_wr_o});
            if (busy) begin
                if (wait_cnt > 1) begin
                    wait_cnt--;
                end else begin
                    busy = 1'b0;
                    mm_data_rdy_i <= 1'b1;
                    if (mm_rd_o) begin
                        mm_rd_data_i <= mem[mm_addr_o[11:2]];
                    end else begin
                        record_store();
                    end
                end
            end else if (!mm_data_rdy_i && (mm_rd_o || mm_wr_o)) begin
                busy     = 1'b1;
                wait_cnt = 1 + ({$random(seed)} % 4);
                if (mm_rd_o && !first_read_seen) begin
                    first_read_seen = 1'b1;
                    check_value("first fetch address", BOOT_ADDR, mm_addr_o);
                end
            end
        end
    end

    initial begin
        int limit;
        int cycles;
        reset_i         = 1'b1;
        mm_data_rdy_i   = 1'b0;
        mm_rd_data_i    = '0;
        errors          = 0;
        store_idx       = 0;
        image_words     = 0;
        wait_cnt        = 0;
        reset_edges     = 0;
        seed            = 79;
        busy            = 1'b0;
        first_read_seen = 1'b0;
        done            = 1'b0;
        load_ok         = 1'b0;
        load_testdata();
        repeat (4) @(posedge clk_i);
        reset_i <= 1'b0;
        // Two memory accesses of up to 4 cycles plus stage overhead per word
        limit  = image_words * (2 * 4 + 4) + 500;
        cycles = 0;
        if (load_ok) begin
            while (!done && cycles < limit) begin
                @(posedge clk_i);
                cycles++;
            end
            if (!done) begin
                errors++;
                $display("timeout, no store to %h within %0d cycles", LAST_STORE_ADDR, limit);
            end
            check_value("store count", exp_addr.size(), store_idx);
        end
        $display("errors: %0d, stores seen: %0d, stores expected: %0d",
                 errors, store_idx, exp_addr.size());
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : tb_segre_core

`default_nettype wire
